// File: dv/mul_checker.sv
`include "mul_settings.svh"
`timescale 1ns/1ns

module mul_checker
    import mul_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    input  operand_t a,
    input  operand_t b,
    input  logic     out_valid,
    input  operand_t hi,
    input  operand_t lo,
    output int       error_count,
    output int       result_count,
    output int       pending
);

    // expected products in issue order, with the edge each one is due
    product_t expected [$];
    int       due [$];
    int       cycle = 0;
    int       errors = 0;
    int       results = 0;
    int       queued = 0;

    assign error_count  = errors;
    assign result_count = results;
    assign pending      = queued;

    task automatic compare_word(input string name, input operand_t want, input operand_t got);
        if (got !== want)
        begin
            $display("Mismatch %s: expected %h, got %h", name, want, got);
            errors++;
        end
    endtask

    always @(posedge clk)
    begin
        product_t want;
        cycle++;
        if (reset)
        begin
            // the DUT drops everything in flight
            expected.delete();
            due.delete();
        end
        else
        begin
            if (out_valid === 1'b1)
            begin
                if (expected.size() == 0)
                begin
                    $display("out_valid high with no product outstanding at cycle %0d", cycle);
                    errors++;
                end
                else
                begin
                    if (due[0] != cycle)
                    begin
                        $display("result due at cycle %0d arrived at cycle %0d", due[0], cycle);
                        errors++;
                    end
                    want = expected.pop_front();
                    void'(due.pop_front());
                    compare_word("hi", want.halves.hi, hi);
                    compare_word("lo", want.halves.lo, lo);
                    results++;
                end
            end
            else if (due.size() > 0 && due[0] <= cycle)
            begin
                $display("out_valid missing for the product due at cycle %0d", due[0]);
                errors++;
                void'(expected.pop_front());
                void'(due.pop_front());
            end

            // sampling edge counts as the first of three
            if (in_valid === 1'b1)
            begin
                want.full = {{`MUL_OPERAND_WIDTH{1'b0}}, a} * {{`MUL_OPERAND_WIDTH{1'b0}}, b};
                expected.push_back(want);
                due.push_back(cycle + 3);
            end
        end
        queued = expected.size();
    end

endmodule

// File: dv/mul_tb.sv
`include "mul_settings.svh"
`timescale 1ns/1ns

module mul_tb
    import mul_pkg::*;
();

    logic     clk;
    logic     reset;
    logic     in_valid;
    operand_t a;
    operand_t b;
    logic     out_valid;
    operand_t hi;
    operand_t lo;

    int       check_errors;
    int       results;
    int       pending;

    int          tb_errors = 0;
    int          tests_done = 0;
    logic [15:0] lfsr_state = 16'd61220;

    // zero, one, all ones, top two bits set
    operand_t corner_a [8] = '{32'h0000_0000, 32'hdead_beef, 32'h0000_0001, 32'h89ab_cdef,
                               32'hffff_ffff, 32'hc000_0000, 32'h8000_0000, 32'hffff_ffff};
    operand_t corner_b [8] = '{32'h1357_9bdf, 32'h0000_0000, 32'h2468_ace0, 32'h0000_0001,
                               32'hffff_ffff, 32'hc000_0000, 32'hffff_ffff, 32'h8000_0001};

    mul32_pipe dut0 (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .out_valid (out_valid),
        .hi        (hi),
        .lo        (lo)
    );

    mul_checker checker0 (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .a            (a),
        .b            (b),
        .out_valid    (out_valid),
        .hi           (hi),
        .lo           (lo),
        .error_count  (check_errors),
        .result_count (results),
        .pending      (pending)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] random_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic int total_errors();
        return tb_errors + check_errors;
    endfunction

    task automatic drive_pair(input operand_t x, input operand_t y, input logic valid);
        @(posedge clk);
        #2;
        in_valid = valid;
        a = x;
        b = y;
    endtask

    task automatic drive_random();
        drive_pair(operand_t'(random_bits(`MUL_OPERAND_WIDTH)),
                   operand_t'(random_bits(`MUL_OPERAND_WIDTH)), 1'b1);
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while ((pending != 0 || out_valid === 1'b1) && cycles < 20)
        begin
            @(negedge clk);
            cycles++;
        end
        if (pending != 0 || out_valid === 1'b1)
        begin
            $display("timed out waiting for the pipeline to drain");
            tb_errors++;
        end
    endtask

    // one isolated pair, counting edges from the sampling edge
    task automatic measure_latency(input operand_t x, input operand_t y);
        int edges;
        drive_pair(x, y, 1'b1);
        drive_pair('0, '0, 1'b0);
        edges = 1;
        @(negedge clk);
        while (out_valid !== 1'b1 && edges < 10)
        begin
            @(posedge clk);
            edges++;
            @(negedge clk);
        end
        if (out_valid !== 1'b1)
        begin
            $display("timed out waiting for out_valid");
            tb_errors++;
        end
        else if (edges != 3)
        begin
            $display("out_valid rose %0d edges after sampling instead of 3", edges);
            tb_errors++;
        end
        @(negedge clk);
        if (out_valid !== 1'b0)
        begin
            $display("out_valid stayed high for more than one cycle");
            tb_errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        int new_errors;
        new_errors = total_errors() - errors_before;
        tests_done++;
        if (new_errors == 0)
            $display("test %0d, %s: ok", tests_done, name);
        else
            $display("test %0d, %s: %0d errors", tests_done, name, new_errors);
    endtask

    initial
    begin
        int start_errors;
        int start_results;
        reset = 1'b1;
        in_valid = 1'b0;
        a = '0;
        b = '0;
        repeat (4) @(posedge clk);
        #2;
        reset = 1'b0;

        start_errors = total_errors();
        for (int i = 0; i < 300; i++)
        begin
            drive_random();
            if (random_bits(2) == 0)
                drive_pair('0, '0, 1'b0);
        end
        drive_pair('0, '0, 1'b0);
        wait_drain();
        report_test("random products", start_errors);

        start_errors = total_errors();
        for (int i = 0; i < 8; i++)
        begin
            drive_pair(corner_a[i], corner_b[i], 1'b1);
        end
        drive_pair('0, '0, 1'b0);
        wait_drain();
        report_test("corner operands", start_errors);

        start_errors = total_errors();
        start_results = results;
        for (int i = 0; i < 50; i++)
        begin
            drive_random();
        end
        drive_pair('0, '0, 1'b0);
        wait_drain();
        if (results - start_results != 50)
        begin
            $display("streaming returned %0d results instead of 50", results - start_results);
            tb_errors++;
        end
        report_test("back-to-back streaming", start_errors);

        start_errors = total_errors();
        for (int i = 0; i < 4; i++)
        begin
            measure_latency(operand_t'(random_bits(`MUL_OPERAND_WIDTH)),
                            operand_t'(random_bits(`MUL_OPERAND_WIDTH)));
        end
        report_test("fixed latency", start_errors);

        // three pairs in flight when reset hits
        start_errors = total_errors();
        for (int i = 0; i < 3; i++)
        begin
            drive_random();
        end
        @(posedge clk);
        #2;
        in_valid = 1'b0;
        reset = 1'b1;
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;
        for (int i = 0; i < 5; i++)
        begin
            @(negedge clk);
            if (out_valid !== 1'b0)
            begin
                $display("out_valid high after reset with nothing issued");
                tb_errors++;
            end
        end
        measure_latency(operand_t'(random_bits(`MUL_OPERAND_WIDTH)),
                        operand_t'(random_bits(`MUL_OPERAND_WIDTH)));
        wait_drain();
        report_test("reset mid-stream", start_errors);

        $display("%0d tests run, %0d errors", tests_done, total_errors());
        if (total_errors() == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

// File: include/mul_settings.svh
`ifndef MUL_SETTINGS_SVH
`define MUL_SETTINGS_SVH

// operand width, one word
`define MUL_OPERAND_WIDTH 32

// full product, two words
`define MUL_PRODUCT_WIDTH 64

// 3:2 levels needed to take 32 rows down to 2
// 32 22 15 10 7 5 4 3 2
`define MUL_CSA_LEVELS 8

`endif

// File: logic/csa_tree.sv
`timescale 1ns/1ns

module csa_tree
    import mul_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  pp_rows_t pp_rows,
    input  logic     pp_valid,
    output row_t     sum_row,
    output row_t     carry_row,
    output logic     csa_valid
);

    // stage[0] holds the incoming rows, stage[l+1] the output of level l
    // entries above the live row count of a level are tied low
    wire row_t stage [0:CSA_LEVELS][0:OPERAND_WIDTH-1];

    genvar l;
    genvar r;
    genvar t;

    generate
        if (rows_after_level(CSA_LEVELS) != 2)
        begin : g_depth_check
            $error("CSA level count does not reduce the rows to two");
        end

        for (r = 0; r < OPERAND_WIDTH; r++)
        begin : g_in
            assign stage[0][r] = pp_rows[r];
        end

        for (l = 0; l < CSA_LEVELS; l++)
        begin : g_level
            localparam int N_IN    = rows_after_level(l);
            localparam int N_OUT   = rows_after_level(l + 1);
            localparam int TRIPLES = N_IN / 3;

            // word-wide full adders, one per triple of rows
            for (t = 0; t < TRIPLES; t++)
            begin : g_csa
                wire row_t x = stage[l][3*t];
                wire row_t y = stage[l][3*t+1];
                wire row_t z = stage[l][3*t+2];

                assign stage[l+1][2*t]   = x ^ y ^ z;
                // majority is the carry into the next column up
                assign stage[l+1][2*t+1] = ((x & y) | (x & z) | (y & z)) << 1;
            end

            // leftover one or two rows go straight through
            for (r = 3 * TRIPLES; r < N_IN; r++)
            begin : g_pass
                assign stage[l+1][r-TRIPLES] = stage[l][r];
            end

            for (r = N_OUT; r < OPERAND_WIDTH; r++)
            begin : g_unused
                assign stage[l+1][r] = '0;
            end
        end
    endgenerate

    always_ff @(posedge clk)
    begin
        if (pp_valid)
        begin
            sum_row   <= stage[CSA_LEVELS][0];
            carry_row <= stage[CSA_LEVELS][1];
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            csa_valid <= 1'b0;
        end
        else
        begin
            csa_valid <= pp_valid;
        end
    end

    // nothing in flight may survive a reset edge
    csa_valid_flushed: assert property (
        @(posedge clk)
        reset |=> !csa_valid ##1 !csa_valid
    )
    else
        $error("csa_valid high within two edges of reset");

endmodule

// File: logic/final_adder.sv
`timescale 1ns/1ns

module final_adder
    import mul_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  row_t     sum_row,
    input  row_t     carry_row,
    input  logic     csa_valid,
    output operand_t hi,
    output operand_t lo,
    output logic     out_valid
);

    // one spare bit on top to catch a carry out
    logic [PRODUCT_WIDTH:0] total;
    product_t               product_q;

    assign total = {1'b0, sum_row} + {1'b0, carry_row};

    always_ff @(posedge clk)
    begin
        if (csa_valid)
        begin
            product_q.full <= total[PRODUCT_WIDTH-1:0];
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            out_valid <= 1'b0;
        end
        else
        begin
            out_valid <= csa_valid;
        end
    end

    assign hi = product_q.halves.hi;
    assign lo = product_q.halves.lo;

    // a 32x32 product always fits in 64 bits, so the tree must never
    // hand over a pair whose sum overflows
    no_carry_out: assert property (
        @(posedge clk) disable iff (reset)
        csa_valid |-> !total[PRODUCT_WIDTH]
    )
    else
        $error("sum and carry rows overflow the product width");

endmodule

// File: logic/mul32_pipe.sv
`timescale 1ns/1ns

module mul32_pipe
    import mul_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    input  operand_t a,
    input  operand_t b,
    output logic     out_valid,
    output operand_t hi,
    output operand_t lo
);

    pp_rows_t pp_rows;
    logic     pp_valid;

    row_t     sum_row;
    row_t     carry_row;
    logic     csa_valid;

    // stage 1, AND array
    partial_product_gen pp_gen0 (
        .clk      (clk),
        .reset    (reset),
        .in_valid (in_valid),
        .a        (a),
        .b        (b),
        .pp_rows  (pp_rows),
        .pp_valid (pp_valid)
    );

    // stage 2, carry-save reduction
    csa_tree tree0 (
        .clk       (clk),
        .reset     (reset),
        .pp_rows   (pp_rows),
        .pp_valid  (pp_valid),
        .sum_row   (sum_row),
        .carry_row (carry_row),
        .csa_valid (csa_valid)
    );

    // stage 3, carry-propagate add
    final_adder add0 (
        .clk       (clk),
        .reset     (reset),
        .sum_row   (sum_row),
        .carry_row (carry_row),
        .csa_valid (csa_valid),
        .hi        (hi),
        .lo        (lo),
        .out_valid (out_valid)
    );

endmodule

// File: logic/mul_pkg.sv
`include "mul_settings.svh"

package mul_pkg;

    localparam int OPERAND_WIDTH = `MUL_OPERAND_WIDTH;
    localparam int PRODUCT_WIDTH = `MUL_PRODUCT_WIDTH;
    localparam int CSA_LEVELS    = `MUL_CSA_LEVELS;

    typedef logic [OPERAND_WIDTH-1:0] operand_t;

    // partial-product row, also used for the sum and carry rows
    typedef logic [PRODUCT_WIDTH-1:0] row_t;

    // one row per multiplier bit
    typedef row_t pp_rows_t [OPERAND_WIDTH];

    typedef struct packed
    {
        operand_t hi;
        operand_t lo;
    } product_halves_t;

    // same 64 bits, seen either whole or as hi/lo words
    typedef union packed
    {
        logic [PRODUCT_WIDTH-1:0] full;
        product_halves_t          halves;
    } product_t;

    // every complete group of three rows becomes two, the rest pass through
    function automatic int rows_after_level(int level);
        int rows;
        rows = OPERAND_WIDTH;
        for (int i = 0; i < level; i++)
        begin
            rows = (rows / 3) * 2 + rows % 3;
        end
        return rows;
    endfunction

endpackage

// File: logic/partial_product_gen.sv
`timescale 1ns/1ns

module partial_product_gen
    import mul_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    input  operand_t a,
    input  operand_t b,
    output pp_rows_t pp_rows,
    output logic     pp_valid
);

    pp_rows_t rows_next;

    // row j is a gated by b[j], moved up j places
    always_comb
    begin
        for (int j = 0; j < OPERAND_WIDTH; j++)
        begin
            rows_next[j] = row_t'(a & {OPERAND_WIDTH{b[j]}}) << j;
        end
    end

    // rows only load with a new operand pair
    always_ff @(posedge clk)
    begin
        if (in_valid)
        begin
            pp_rows <= rows_next;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pp_valid <= 1'b0;
        end
        else
        begin
            pp_valid <= in_valid;
        end
    end

    // an X strobe would corrupt every valid bit further down the pipe
    in_valid_known: assert property (
        @(posedge clk) disable iff (reset)
        !$isunknown(in_valid)
    )
    else
        $error("in_valid is unknown while out of reset");

endmodule

// File: verilog.f
+incdir+include
logic/mul_pkg.sv
logic/partial_product_gen.sv
logic/csa_tree.sv
logic/final_adder.sv
logic/mul32_pipe.sv
dv/mul_checker.sv
dv/mul_tb.sv
